// ==== calculate_current_state.sv ====
`timescale 1ns/1ps
`include "vend_cfg.svh"

module calculate_current_state (
	input  vend_pkg::coin_vec_t i_input_coin,
	input  vend_pkg::item_vec_t i_select_item,
	input  vend_pkg::total_t    i_current_total,
	input  vend_pkg::wait_t     i_wait_time,
	input  vend_pkg::coin_vec_t i_return_coin,
	output vend_pkg::total_t    o_current_total_nxt,
	output vend_pkg::item_vec_t o_available_item,
	output vend_pkg::item_vec_t o_output_item,
	output logic                o_activity
);
	import vend_pkg::*;

	// Session open while the timer runs
	logic   session_open;
	logic   coin_accepted;
	total_t input_total;
	total_t output_total;
	total_t return_total;

	assign session_open = (i_wait_time != '0);
	assign coin_accepted = session_open && (|i_input_coin);

	// Next credit and dispensed items
	always_comb begin
		input_total = '0;
		output_total = '0;
		return_total = '0;
		o_output_item = '0;

		if (session_open) begin
			// Sum of inserted coins
			for (int i = 0; i < `kNumCoins; i++) begin
				if (i_input_coin[i]) begin
					input_total = input_total + coin_value(i);
				end
			end

			// Each selection checked against what is left after earlier ones
			for (int i = 0; i < `kNumItems; i++) begin
				if (i_select_item[i] &&
					((i_current_total - output_total) >= item_price(i))) begin
					output_total = output_total + item_price(i);
					o_output_item[i] = 1'b1;
				end
			end
		end

		// Paid-out change leaves the credit whether or not the session is open
		for (int i = 0; i < `kNumCoins; i++) begin
			if (i_return_coin[i]) begin
				return_total = return_total + coin_value(i);
			end
		end

		o_current_total_nxt = i_current_total + input_total - output_total - return_total;
	end

	// Items the registered credit can buy
	always_comb begin
		o_available_item = '0;
		for (int i = 0; i < `kNumItems; i++) begin
			o_available_item[i] = (i_current_total >= item_price(i));
		end
	end

	// Any accepted coin or sale keeps the session alive
	assign o_activity = coin_accepted || (|o_output_item);

endmodule

// ==== compile.f ====
+incdir+.
vend_pkg.sv
calculate_current_state.sv
vend_wait_timer.sv
vend_return_fsm.sv
vend_change_unit.sv
vending_machine.sv
tb_vending_machine.sv

// ==== tb_vending_machine.sv ====
`timescale 1ns/1ps
`include "vend_cfg.svh"

module tb_vending_machine;
	import vend_pkg::*;

	localparam int kRows = 14;

	logic      clk;
	logic      i_arst_n;
	vend_req_t i_req;
	item_vec_t o_available_item;
	item_vec_t o_output_item;
	coin_vec_t o_return_coin;

	// Reference values taken straight from the configuration
	int unsigned coin_val [`kNumCoins] = '{`kCoinValue0, `kCoinValue1, `kCoinValue2};
	int unsigned item_val [`kNumItems] = '{`kItemPrice0, `kItemPrice1, `kItemPrice2,
		`kItemPrice3};

	// Stimulus table and expected dispensed items
	vend_req_t   tbl_req [kRows];
	item_vec_t   tbl_out [kRows];
	int unsigned model_total;
	integer      seed = 32'hb823_a423;

	vending_machine dut0 (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.i_req            (i_req),
		.o_available_item (o_available_item),
		.o_output_item    (o_output_item),
		.o_return_coin    (o_return_coin)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hard cycle limit for the whole run
	initial begin
		repeat (5000) @(posedge clk);
		$display("Error: simulation ran past its cycle limit");
		stop_run();
	end

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_item(input string name, input item_vec_t exp, input item_vec_t act);
		if (exp !== act) begin
			$display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_coin(input string name, input coin_vec_t exp, input coin_vec_t act);
		if (exp !== act) begin
			$display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
			stop_run();
		end
	endtask

	// Items whose price fits a credit
	function automatic item_vec_t avail_for(input int unsigned total);
		item_vec_t v;
		for (int i = 0; i < `kNumItems; i++) begin
			v[i] = (total >= item_val[i]);
		end
		return v;
	endfunction

	// Selected items bought in index order against what is left
	function automatic item_vec_t predict_out(input item_vec_t sel, input int unsigned total);
		item_vec_t   v;
		int unsigned spent;
		v = '0;
		spent = 0;
		for (int i = 0; i < `kNumItems; i++) begin
			if (sel[i] && (total - spent >= item_val[i])) begin
				v[i] = 1'b1;
				spent += item_val[i];
			end
		end
		return v;
	endfunction

	function automatic int unsigned coin_sum(input coin_vec_t coins);
		int unsigned s;
		s = 0;
		for (int i = 0; i < `kNumCoins; i++) begin
			if (coins[i]) s += coin_val[i];
		end
		return s;
	endfunction

	function automatic int unsigned price_sum(input item_vec_t items);
		int unsigned s;
		s = 0;
		for (int i = 0; i < `kNumItems; i++) begin
			if (items[i]) s += item_val[i];
		end
		return s;
	endfunction

	// Largest coin not above the remaining credit
	function automatic coin_vec_t greedy_coin(input int unsigned total);
		coin_vec_t v;
		v = '0;
		for (int i = `kNumCoins - 1; i >= 0; i--) begin
			if (v == '0 && total >= coin_val[i]) v[i] = 1'b1;
		end
		return v;
	endfunction

	task automatic set_row(input int idx, input coin_vec_t c, input item_vec_t s,
		input item_vec_t e);
		vend_req_t r;
		r.coin = c;
		r.select = s;
		r.ret = 1'b0;
		tbl_req[idx] = r;
		tbl_out[idx] = e;
	endtask

	// Credit trace in the trailing notes
	task automatic load_table();
		set_row(0, 3'b001, 4'b0000, 4'b0000);  // 100
		set_row(1, 3'b010, 4'b0000, 4'b0000);  // 600
		set_row(2, 3'b100, 4'b0000, 4'b0000);  // 1600
		set_row(3, 3'b000, 4'b1000, 4'b0000);  // 2000 too dear
		set_row(4, 3'b000, 4'b0100, 4'b0100);  // 600
		set_row(5, 3'b000, 4'b0010, 4'b0010);  // 100
		set_row(6, 3'b000, 4'b0001, 4'b0000);  // 400 too dear
		set_row(7, 3'b100, 4'b0000, 4'b0000);  // 1100
		set_row(8, 3'b100, 4'b0000, 4'b0000);  // 2100
		set_row(9, 3'b000, 4'b1000, 4'b1000);  // 100
		set_row(10, 3'b011, 4'b0000, 4'b0000); // 700
		// Coin and sale together with the price checked against the old credit
		set_row(11, 3'b010, 4'b0001, 4'b0001); // 800
		set_row(12, 3'b000, 4'b0001, 4'b0001); // 400
		set_row(13, 3'b001, 4'b0000, 4'b0000); // 500
	endtask

	// Drive one request, check at the falling edge, then advance the model
	task automatic apply_row(input vend_req_t req, input item_vec_t exp_out);
		@(posedge clk);
		i_req <= req;
		@(negedge clk);
		check_item("o_available_item", avail_for(model_total), o_available_item);
		check_item("o_output_item", exp_out, o_output_item);
		check_coin("o_return_coin", '0, o_return_coin);
		model_total = model_total + coin_sum(req.coin) - price_sum(exp_out);
	endtask

	task automatic go_idle();
		@(posedge clk);
		i_req <= '0;
		@(negedge clk);
	endtask

	// Wait for change, then follow every coin until the credit is drained
	task automatic run_payout(input int limit, input int min_wait);
		int n;
		n = 0;
		while (o_return_coin == '0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (o_return_coin == '0) begin
			$display("Error: change payout did not start within %0d cycles", limit);
			stop_run();
		end
		if (n < min_wait) begin
			$display("Error: change payout started after %0d cycles, session still open", n);
			stop_run();
		end
		n = 0;
		while (o_return_coin != '0 && n < 200) begin
			check_coin("o_return_coin", greedy_coin(model_total), o_return_coin);
			model_total -= coin_sum(o_return_coin);
			@(negedge clk);
			n++;
		end
		if (o_return_coin != '0) begin
			$display("Error: change payout did not finish");
			stop_run();
		end
		if (model_total != 0) begin
			$display("Error: payout stopped with %0d credit still owed", model_total);
			stop_run();
		end
		check_item("o_available_item", '0, o_available_item);
	endtask

	task automatic press_return();
		vend_req_t r;
		r = '0;
		r.ret = 1'b1;
		@(posedge clk);
		i_req <= r;
		@(posedge clk);
		i_req <= '0;
		@(negedge clk);
		run_payout(8, 1);
	endtask

	initial begin
		vend_req_t   req;
		item_vec_t   exp_out;
		logic [31:0] rnd;
		int          idle_cnt;
		i_arst_n = 1'b0;
		i_req = '0;
		model_total = 0;
		idle_cnt = 0;
		load_table();
		repeat (3) @(posedge clk);
		i_arst_n <= 1'b1;
		@(negedge clk);
		check_item("o_available_item", '0, o_available_item);
		check_item("o_output_item", '0, o_output_item);
		check_coin("o_return_coin", '0, o_return_coin);

		// Coins, affordable and unaffordable selections
		for (int k = 0; k < kRows; k++) begin
			apply_row(tbl_req[k], tbl_out[k]);
		end

		// Return button pays out the rest
		press_return();

		// Expired session pays out by itself
		req = '0;
		req.coin = 3'b100;
		apply_row(req, '0);
		req.coin = 3'b001;
		apply_row(req, '0);
		go_idle();
		run_payout(`kWaitTime + 20, `kWaitTime);

		// Random coins and single selections with a coin forced after a short idle run
		for (int k = 0; k < 200; k++) begin
			rnd = $random(seed);
			req = '0;
			if (model_total > 20000) begin
				req.select = 4'b1000;
			end else if (idle_cnt >= 10 || rnd[3:0] < 4'd10) begin
				req.coin = coin_vec_t'(1) << (rnd[9:8] % 3);
			end else begin
				req.select = item_vec_t'(1) << rnd[13:12];
			end
			exp_out = predict_out(req.select, model_total);
			if (req.coin == '0 && exp_out == '0) idle_cnt++;
			else idle_cnt = 0;
			apply_row(req, exp_out);
		end
		req = '0;
		req.coin = 3'b100;
		apply_row(req, '0);
		press_return();

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== vend_cfg.svh ====
`ifndef VEND_CFG_SVH
`define VEND_CFG_SVH

// Number of coin types and items
`define kNumCoins 3
`define kNumItems 4

// Credit and timer widths
`define kTotalBits 16
`define kWaitBits 16

// Session length in clock cycles
`define kWaitTime 100

// Coin values, ascending with index
`define kCoinValue0 100
`define kCoinValue1 500
`define kCoinValue2 1000

// Item prices
`define kItemPrice0 400
`define kItemPrice1 500
`define kItemPrice2 1000
`define kItemPrice3 2000

`endif

// ==== vend_change_unit.sv ====
`timescale 1ns/1ps
`include "vend_cfg.svh"

module vend_change_unit (
	input  logic                clk,
	input  logic                i_arst_n,
	input  vend_pkg::total_t    i_current_total_nxt,
	input  logic                i_return_en,
	output vend_pkg::total_t    o_current_total,
	output vend_pkg::coin_vec_t o_return_coin
);
	import vend_pkg::*;

	// Set once a coin has been picked in the scan
	logic coin_found;

	// Credit register
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_current_total <= '0;
		end else begin
			o_current_total <= i_current_total_nxt;
		end
	end

	// Greedy change selector
	always_comb begin
		o_return_coin = '0;
		coin_found = 1'b0;
		if (i_return_en) begin
			// Scan from the largest coin down
			for (int i = `kNumCoins - 1; i >= 0; i--) begin
				if (!coin_found && (o_current_total >= coin_value(i))) begin
					o_return_coin[i] = 1'b1;
					coin_found = 1'b1;
				end
			end
		end
	end

	// Credit always a multiple of the smallest coin, so a coin always fits

endmodule

// ==== vend_pkg.sv ====
`include "vend_cfg.svh"

package vend_pkg;

	// One bit per coin type, one bit per item
	typedef logic [`kNumCoins-1:0] coin_vec_t;
	typedef logic [`kNumItems-1:0] item_vec_t;

	// Credit amount and remaining session cycles
	typedef logic [`kTotalBits-1:0] total_t;
	typedef logic [`kWaitBits-1:0] wait_t;

	// Customer request for one cycle, all bits are pulses
	typedef struct packed {
		coin_vec_t coin;
		item_vec_t select;
		logic      ret;
	} vend_req_t;

	// Payout state
	typedef enum logic [0:0] {
		RS_IDLE   = 1'b0,
		RS_RETURN = 1'b1
	} ret_state_t;

	// Coin index to value
	function automatic total_t coin_value(input int unsigned idx);
		total_t val;
		case (idx)
			0: val = total_t'(`kCoinValue0);
			1: val = total_t'(`kCoinValue1);
			2: val = total_t'(`kCoinValue2);
			default: val = '0;
		endcase
		return val;
	endfunction

	// Item index to price
	function automatic total_t item_price(input int unsigned idx);
		total_t val;
		case (idx)
			0: val = total_t'(`kItemPrice0);
			1: val = total_t'(`kItemPrice1);
			2: val = total_t'(`kItemPrice2);
			3: val = total_t'(`kItemPrice3);
			default: val = '0;
		endcase
		return val;
	endfunction

endpackage

// ==== vend_return_fsm.sv ====
`timescale 1ns/1ps

module vend_return_fsm (
	input  logic             clk,
	input  logic             i_arst_n,
	input  vend_pkg::wait_t  i_wait_time,
	input  vend_pkg::total_t i_current_total,
	output logic             o_return_en,
	output logic             o_return_done
);
	import vend_pkg::*;

	ret_state_t state;
	ret_state_t state_nxt;
	logic       credit_empty;

	assign credit_empty = (i_current_total == '0);

	// State register
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= RS_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			RS_IDLE: begin
				// Expired session starts a payout
				if (i_wait_time == '0) begin
					state_nxt = RS_RETURN;
				end
			end
			RS_RETURN: begin
				// Drained credit ends the payout
				if (credit_empty) begin
					state_nxt = RS_IDLE;
				end
			end
			default: state_nxt = RS_IDLE;
		endcase
	end

	// One coin per cycle while credit remains
	assign o_return_en = (state == RS_RETURN) && !credit_empty;

	// Single cycle, the timer reloads on the same edge we leave RS_RETURN
	assign o_return_done = (state == RS_RETURN) && credit_empty;

endmodule

// ==== vend_wait_timer.sv ====
`timescale 1ns/1ps
`include "vend_cfg.svh"

module vend_wait_timer (
	input  logic            clk,
	input  logic            i_arst_n,
	input  logic            i_activity,
	input  logic            i_return_req,
	input  logic            i_return_done,
	output vend_pkg::wait_t o_wait_time
);
	import vend_pkg::*;

	// Full session length
	localparam wait_t kReload = wait_t'(`kWaitTime);

	// Countdown register
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wait_time <= kReload;
		end else if (i_return_req) begin
			// Return button ends the session at once
			o_wait_time <= '0;
		end else if (i_activity || i_return_done) begin
			// New coin, sale or finished payout starts a fresh session
			o_wait_time <= kReload;
		end else if (o_wait_time != '0) begin
			o_wait_time <= o_wait_time - wait_t'(1);
		end
	end

	// Holds at zero until the payout finishes

endmodule

// ==== vending_machine.sv ====
`timescale 1ns/1ps

module vending_machine (
	input  logic                clk,
	input  logic                i_arst_n,
	input  vend_pkg::vend_req_t i_req,
	output vend_pkg::item_vec_t o_available_item,
	output vend_pkg::item_vec_t o_output_item,
	output vend_pkg::coin_vec_t o_return_coin
);
	import vend_pkg::*;

	// Credit loop
	total_t current_total;
	total_t current_total_nxt;

	// Session control
	wait_t wait_time;
	logic  activity;
	logic  return_en;
	logic  return_done;

	// Next credit, available and dispensed items
	calculate_current_state u_calc (
		.i_input_coin        (i_req.coin),
		.i_select_item       (i_req.select),
		.i_current_total     (current_total),
		.i_wait_time         (wait_time),
		.i_return_coin       (o_return_coin),
		.o_current_total_nxt (current_total_nxt),
		.o_available_item    (o_available_item),
		.o_output_item       (o_output_item),
		.o_activity          (activity)
	);

	// Session countdown
	vend_wait_timer u_timer (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_activity    (activity),
		.i_return_req  (i_req.ret),
		.i_return_done (return_done),
		.o_wait_time   (wait_time)
	);

	// Payout control
	vend_return_fsm u_fsm (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_wait_time     (wait_time),
		.i_current_total (current_total),
		.o_return_en     (return_en),
		.o_return_done   (return_done)
	);

	// Credit register and change coins
	vend_change_unit u_change (
		.clk                 (clk),
		.i_arst_n            (i_arst_n),
		.i_current_total_nxt (current_total_nxt),
		.i_return_en         (return_en),
		.o_current_total     (current_total),
		.o_return_coin       (o_return_coin)
	);

endmodule
